//--- rtl/soc_bus_pkg.sv
// Wishbone bus shape shared by the decoder and every slave.
// Widths of address, data, byte selects and register index.
package soc_bus_pkg;

	// ******************************
	// bus widths
	// ******************************
	localparam int ADDR_W = 16;
	localparam int DATA_W = 32;
	localparam int SEL_W  = DATA_W / 8;
	localparam int IDX_W  = 3;

	typedef logic [ADDR_W-1:0] wb_addr_t; // byte address.
	typedef logic [DATA_W-1:0] wb_data_t;
	typedef logic [SEL_W-1:0]  wb_sel_t;  // one bit per byte lane.

	// word index inside a region, taken from address bits 4:2.
	typedef logic [IDX_W-1:0] reg_idx_t;

endpackage

//--- rtl/soc_map_pkg.sv
// System map: device regions, device ids, interrupt sources
// and the software reset command encoding.
package soc_map_pkg;

	// ******************************
	// address map
	// ******************************
	localparam int REGION_SHIFT = 12; // each device owns 4 KB.

	// address bits 15:12 pick the region; the other values are unmapped.
	typedef enum logic [3:0] {
		DEV_TABLE = 4'd0,
		DEV_GPIO  = 4'd1,
		DEV_INTC  = 4'd2
	} dev_e;

	localparam logic [15:0] DEV_ID_TABLE = 16'h0001;
	localparam logic [15:0] DEV_ID_GPIO  = 16'h0002;
	localparam logic [15:0] DEV_ID_INTC  = 16'h0003;

	// ******************************
	// reset commands
	// ******************************
	// bit 0 is rst0 and bit 1 is rst1.
	typedef enum logic [1:0] {
		RST_CMD_NONE = 2'd0,
		RST_CMD_OFF  = 2'd1,
		RST_CMD_WARM = 2'd2,
		RST_CMD_COLD = 2'd3
	} rst_cmd_e;

	// ******************************
	// interrupt sources
	// ******************************
	localparam int INT_SRC_GPIO   = 0;
	localparam int INT_SRC_BUSERR = 1;
	localparam int INT_SRC_COUNT  = 2;

	typedef logic [INT_SRC_COUNT-1:0] int_vec_t;

endpackage

//--- rtl/wb_if.sv
`timescale 1ns/1ns
// Wishbone classic link between the address decoder and one slave.
interface wb_if;

	logic                  cyc;
	logic                  stb;
	logic                  we;
	soc_bus_pkg::wb_addr_t adr;
	soc_bus_pkg::wb_data_t dat_w;
	soc_bus_pkg::wb_sel_t  sel;
	soc_bus_pkg::wb_data_t dat_r; // valid while ack is high.
	logic                  ack;

	// the decoder side.
	modport master (
		output cyc,
		output stb,
		output we,
		output adr,
		output dat_w,
		output sel,
		input  dat_r,
		input  ack
	);

	modport slave (
		input  cyc,
		input  stb,
		input  we,
		input  adr,
		input  dat_w,
		input  sel,
		output dat_r,
		output ack
	);

endinterface

//--- rtl/sys_ctrl.sv
`timescale 1ns/1ns
// System controller: reset counter, software reset and power-off handling,
// and the rate-limited bus activity blink.
module sys_ctrl #(
	parameter int RESET_CYCLES = 16,
	parameter int ACT_HOLD     = 127
) (
	input  logic                  clk100mhz,
	input  logic                  rst_p,
	input  soc_map_pkg::rst_cmd_e rst_cmd_i,
	input  logic                  bus_active_i,
	output logic                  sys_rst_o,
	output logic                  pwr_off_o,
	output logic                  activity_o
);

	localparam int RST_CNT_W = $clog2(RESET_CYCLES + 1);
	localparam int ACT_CNT_W = $clog2(ACT_HOLD + 1);

	typedef enum logic [1:0] {
		HOLD,
		RUN,
		OFF
	} state_e;

	state_e               state;
	logic [RST_CNT_W-1:0] rst_cnt;
	logic [ACT_CNT_W-1:0] act_cnt;

	// ******************************
	// reset sequencing
	// ******************************
	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			state   <= HOLD;
			rst_cnt <= RST_CNT_W'(RESET_CYCLES);
		end else begin
			case (state)
				HOLD: begin
					// leaves reset on the RESET_CYCLES-th edge after rst_p falls.
					if (rst_cnt == RST_CNT_W'(1))
						state <= RUN;
					rst_cnt <= rst_cnt - 1'b1;
				end
				RUN: begin
					case (rst_cmd_i)
						soc_map_pkg::RST_CMD_OFF: state <= OFF;
						// with no global set/reset, cold restarts the same way as warm.
						soc_map_pkg::RST_CMD_WARM, soc_map_pkg::RST_CMD_COLD: begin
							state   <= HOLD;
							rst_cnt <= RST_CNT_W'(RESET_CYCLES);
						end
						default: state <= RUN;
					endcase
				end
				OFF: state <= OFF; // only rst_p brings the system back.
				default: begin
					state   <= HOLD;
					rst_cnt <= RST_CNT_W'(RESET_CYCLES);
				end
			endcase
		end
	end

	assign sys_rst_o = (state != RUN);
	assign pwr_off_o = (state == OFF);

	// ******************************
	// activity blink
	// ******************************
	always_ff @(posedge clk100mhz) begin
		if (rst_p || sys_rst_o) begin
			act_cnt    <= '0;
			activity_o <= 1'b0;
		end else if (act_cnt != '0) begin
			act_cnt    <= act_cnt - 1'b1; // no new pulse until this runs out.
			activity_o <= 1'b0;
		end else begin
			activity_o <= bus_active_i;
			if (bus_active_i)
				act_cnt <= ACT_CNT_W'(ACT_HOLD);
		end
	end

	// reset is released only after a full countdown.
	reset_held_full_count: assert property (@(posedge clk100mhz) disable iff (rst_p)
		$fell(sys_rst_o) |-> $past(sys_rst_o, RESET_CYCLES));

endmodule

//--- rtl/bus_decoder.sv
`timescale 1ns/1ns
// Address decoder: routes the single bus master to one device region
// and answers unmapped regions with zero data and a bus error pulse.
module bus_decoder (
	input  logic                  clk100mhz,
	input  logic                  rst_i,
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	input  logic                  wb_we_i,
	input  soc_bus_pkg::wb_addr_t wb_adr_i,
	input  soc_bus_pkg::wb_data_t wb_dat_i,
	input  soc_bus_pkg::wb_sel_t  wb_sel_i,
	output soc_bus_pkg::wb_data_t wb_dat_o,
	output logic                  wb_ack_o,
	wb_if.master                  tbl_o,
	wb_if.master                  gpio_o,
	wb_if.master                  intc_o,
	output logic                  bus_active_o,
	output logic                  bus_err_o
);

	soc_map_pkg::dev_e region;
	logic              req;
	logic              unmapped;
	logic              inv_ack;

	assign req    = wb_cyc_i && wb_stb_i;
	assign region = soc_map_pkg::dev_e'(wb_adr_i[soc_map_pkg::REGION_SHIFT +:
		$bits(soc_map_pkg::dev_e)]);

	// ******************************
	// request fan-out
	// ******************************
	assign tbl_o.cyc   = wb_cyc_i;
	assign tbl_o.stb   = wb_stb_i && (region == soc_map_pkg::DEV_TABLE);
	assign tbl_o.we    = wb_we_i;
	assign tbl_o.adr   = wb_adr_i;
	assign tbl_o.dat_w = wb_dat_i;
	assign tbl_o.sel   = wb_sel_i;

	assign gpio_o.cyc   = wb_cyc_i;
	assign gpio_o.stb   = wb_stb_i && (region == soc_map_pkg::DEV_GPIO);
	assign gpio_o.we    = wb_we_i;
	assign gpio_o.adr   = wb_adr_i;
	assign gpio_o.dat_w = wb_dat_i;
	assign gpio_o.sel   = wb_sel_i;

	assign intc_o.cyc   = wb_cyc_i;
	assign intc_o.stb   = wb_stb_i && (region == soc_map_pkg::DEV_INTC);
	assign intc_o.we    = wb_we_i;
	assign intc_o.adr   = wb_adr_i;
	assign intc_o.dat_w = wb_dat_i;
	assign intc_o.sel   = wb_sel_i;

	// response mux; the address is held until ack so the region is stable.
	always_comb begin
		wb_ack_o = inv_ack;
		wb_dat_o = '0;
		unmapped = 1'b1;
		case (region)
			soc_map_pkg::DEV_TABLE: begin
				wb_ack_o = tbl_o.ack;
				wb_dat_o = tbl_o.dat_r;
				unmapped = 1'b0;
			end
			soc_map_pkg::DEV_GPIO: begin
				wb_ack_o = gpio_o.ack;
				wb_dat_o = gpio_o.dat_r;
				unmapped = 1'b0;
			end
			soc_map_pkg::DEV_INTC: begin
				wb_ack_o = intc_o.ack;
				wb_dat_o = intc_o.dat_r;
				unmapped = 1'b0;
			end
			default: unmapped = 1'b1;
		endcase
	end

	// invalid-device responder, one cycle like every real slave.
	always_ff @(posedge clk100mhz) begin
		if (rst_i)
			inv_ack <= 1'b0;
		else
			inv_ack <= req && unmapped && !inv_ack;
	end

	assign bus_err_o    = inv_ack; // pulses at the error ack.
	assign bus_active_o = req;

	only_one_slave_acks: assert property (@(posedge clk100mhz) disable iff (rst_i)
		$onehot0({tbl_o.ack, gpio_o.ack, intc_o.ack}));

endmodule

//--- rtl/dev_table.sv
`timescale 1ns/1ns
// Device table: read-only descriptors of the mapped devices,
// plus the software reset command register.
module dev_table (
	input  logic                  clk100mhz,
	input  logic                  rst_i,
	wb_if.slave                   bus_s,
	output soc_map_pkg::rst_cmd_e rst_cmd_o
);

	localparam soc_bus_pkg::reg_idx_t RST_CMD_WORD = 3'd4;

	soc_bus_pkg::reg_idx_t idx;
	soc_bus_pkg::wb_data_t rd_data;
	logic                  accept;

	// id in the top half, region size as a shift in the low byte.
	function automatic soc_bus_pkg::wb_data_t descriptor(input logic [15:0] dev_id);
		return {dev_id, 8'h00, 8'(soc_map_pkg::REGION_SHIFT)};
	endfunction

	assign idx    = bus_s.adr[4:2];
	assign accept = bus_s.cyc && bus_s.stb && !bus_s.ack;

	always_comb begin
		case (idx)
			3'd0: rd_data = descriptor(soc_map_pkg::DEV_ID_TABLE);
			3'd1: rd_data = descriptor(soc_map_pkg::DEV_ID_GPIO);
			3'd2: rd_data = descriptor(soc_map_pkg::DEV_ID_INTC);
			default: rd_data = '0;
		endcase
	end

	always_ff @(posedge clk100mhz) begin
		if (rst_i) begin
			bus_s.ack <= 1'b0;
			rst_cmd_o <= soc_map_pkg::RST_CMD_NONE;
		end else begin
			bus_s.ack <= accept;
			rst_cmd_o <= soc_map_pkg::RST_CMD_NONE; // the command is a single pulse.
			if (accept && bus_s.we && bus_s.sel[0] && (idx == RST_CMD_WORD))
				rst_cmd_o <= soc_map_pkg::rst_cmd_e'(bus_s.dat_w[1:0]);
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (accept)
			bus_s.dat_r <= rd_data;
	end

endmodule

//--- rtl/gpio_port.sv
`timescale 1ns/1ns
// GPIO block: synchronized inputs, an output register and an input change event.
module gpio_port #(
	parameter int GPIO_W = 16
) (
	input  logic              clk100mhz,
	input  logic              rst_i,
	wb_if.slave               bus_s,
	input  logic [GPIO_W-1:0] gp_i,
	output logic [GPIO_W-1:0] gp_o,
	output logic              change_o
);

	logic [GPIO_W-1:0]     gp_meta;
	logic [GPIO_W-1:0]     gp_sync;
	logic [GPIO_W-1:0]     gp_prev;
	soc_bus_pkg::wb_data_t wr_mask;
	soc_bus_pkg::wb_data_t rd_data;
	soc_bus_pkg::reg_idx_t idx;
	logic                  accept;

	assign idx    = bus_s.adr[4:2];
	assign accept = bus_s.cyc && bus_s.stb && !bus_s.ack;

	// byte lane selects widened to a bit mask.
	always_comb begin
		for (int b = 0; b < $bits(soc_bus_pkg::wb_sel_t); b++)
			wr_mask[8*b +: 8] = {8{bus_s.sel[b]}};
	end

	always_comb begin
		case (idx)
			3'd0: rd_data = soc_bus_pkg::wb_data_t'(gp_sync);
			3'd1: rd_data = soc_bus_pkg::wb_data_t'(gp_o);
			default: rd_data = '0;
		endcase
	end

	always_ff @(posedge clk100mhz) begin
		if (rst_i) begin
			gp_meta   <= '0;
			gp_sync   <= '0;
			gp_prev   <= '0;
			gp_o      <= '0;
			bus_s.ack <= 1'b0;
		end else begin
			gp_meta   <= gp_i; // two-flop synchronizer.
			gp_sync   <= gp_meta;
			gp_prev   <= gp_sync;
			bus_s.ack <= accept;
			if (accept && bus_s.we && (idx == 3'd1))
				gp_o <= (gp_o & ~wr_mask[GPIO_W-1:0]) |
					(bus_s.dat_w[GPIO_W-1:0] & wr_mask[GPIO_W-1:0]);
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (accept)
			bus_s.dat_r <= rd_data;
	end

	assign change_o = (gp_sync != gp_prev);

endmodule

//--- rtl/int_ctrl.sv
`timescale 1ns/1ns
// Interrupt controller: latches source pulses as pending bits
// and raises the interrupt line for enabled pending sources.
module int_ctrl (
	input  logic                  clk100mhz,
	input  logic                  rst_i,
	wb_if.slave                   bus_s,
	input  soc_map_pkg::int_vec_t src_i,
	output logic                  irq_o
);

	soc_map_pkg::int_vec_t pending;
	soc_map_pkg::int_vec_t enable;
	soc_map_pkg::int_vec_t clr_mask;
	soc_bus_pkg::wb_data_t rd_data;
	soc_bus_pkg::reg_idx_t idx;
	logic                  accept;
	logic                  wr_byte0;

	assign idx      = bus_s.adr[4:2];
	assign accept   = bus_s.cyc && bus_s.stb && !bus_s.ack;
	assign wr_byte0 = accept && bus_s.we && bus_s.sel[0];

	// writing ones to word 0 clears those pending bits.
	assign clr_mask = (wr_byte0 && (idx == 3'd0)) ?
		bus_s.dat_w[soc_map_pkg::INT_SRC_COUNT-1:0] : '0;

	always_comb begin
		case (idx)
			3'd0: rd_data = soc_bus_pkg::wb_data_t'(pending);
			3'd1: rd_data = soc_bus_pkg::wb_data_t'(enable);
			default: rd_data = '0;
		endcase
	end

	always_ff @(posedge clk100mhz) begin
		if (rst_i) begin
			pending   <= '0;
			enable    <= '0;
			irq_o     <= 1'b0;
			bus_s.ack <= 1'b0;
		end else begin
			bus_s.ack <= accept;
			pending   <= (pending & ~clr_mask) | src_i; // a new event wins over a clear.
			irq_o     <= |(pending & enable);
			if (wr_byte0 && (idx == 3'd1))
				enable <= bus_s.dat_w[soc_map_pkg::INT_SRC_COUNT-1:0];
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (accept)
			bus_s.dat_r <= rd_data;
	end

	// an enabled source event reaches irq_o two edges later.
	event_raises_irq: assert property (@(posedge clk100mhz) disable iff (rst_i)
		(|(src_i & enable) && !(wr_byte0 && (idx == 3'd1))) |=> ##1 irq_o);

endmodule

//--- rtl/soc_top.sv
`timescale 1ns/1ns
// System top: reset and power control, address decoding, device table,
// GPIO and interrupt controller behind one external Wishbone master.
module soc_top #(
	parameter int GPIO_W       = 16,
	parameter int RESET_CYCLES = 16,
	parameter int ACT_HOLD     = 127
) (
	input  logic                  clk100mhz,
	input  logic                  rst_p,
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	input  logic                  wb_we_i,
	input  soc_bus_pkg::wb_addr_t wb_adr_i,
	input  soc_bus_pkg::wb_data_t wb_dat_i,
	input  soc_bus_pkg::wb_sel_t  wb_sel_i,
	output soc_bus_pkg::wb_data_t wb_dat_o,
	output logic                  wb_ack_o,
	input  logic [GPIO_W-1:0]     gp_i,
	output logic [GPIO_W-1:0]     gp_o,
	output logic                  irq_o,
	output logic                  activity_o,
	output logic                  sys_rst_o,
	output logic                  pwr_off_o
);

	soc_map_pkg::rst_cmd_e rst_cmd;
	soc_map_pkg::int_vec_t int_src;
	logic                  bus_active;
	logic                  bus_err;
	logic                  gpio_change;

	wb_if wb_tbl ();
	wb_if wb_gpio ();
	wb_if wb_intc ();

	assign int_src[soc_map_pkg::INT_SRC_GPIO]   = gpio_change;
	assign int_src[soc_map_pkg::INT_SRC_BUSERR] = bus_err;

	// ******************************
	// control
	// ******************************
	sys_ctrl #(
		.RESET_CYCLES (RESET_CYCLES),
		.ACT_HOLD     (ACT_HOLD)
	) sys_ctrl_i (
		.clk100mhz    (clk100mhz),
		.rst_p        (rst_p),
		.rst_cmd_i    (rst_cmd),
		.bus_active_i (bus_active),
		.sys_rst_o    (sys_rst_o),
		.pwr_off_o    (pwr_off_o),
		.activity_o   (activity_o)
	);

	bus_decoder bus_decoder_i (
		.clk100mhz    (clk100mhz),
		.rst_i        (sys_rst_o),
		.wb_cyc_i     (wb_cyc_i),
		.wb_stb_i     (wb_stb_i),
		.wb_we_i      (wb_we_i),
		.wb_adr_i     (wb_adr_i),
		.wb_dat_i     (wb_dat_i),
		.wb_sel_i     (wb_sel_i),
		.wb_dat_o     (wb_dat_o),
		.wb_ack_o     (wb_ack_o),
		.tbl_o        (wb_tbl),
		.gpio_o       (wb_gpio),
		.intc_o       (wb_intc),
		.bus_active_o (bus_active),
		.bus_err_o    (bus_err)
	);

	// ******************************
	// devices
	// ******************************
	dev_table dev_table_i (
		.clk100mhz (clk100mhz),
		.rst_i     (sys_rst_o),
		.bus_s     (wb_tbl),
		.rst_cmd_o (rst_cmd)
	);

	gpio_port #(
		.GPIO_W (GPIO_W)
	) gpio_port_i (
		.clk100mhz (clk100mhz),
		.rst_i     (sys_rst_o),
		.bus_s     (wb_gpio),
		.gp_i      (gp_i),
		.gp_o      (gp_o),
		.change_o  (gpio_change)
	);

	int_ctrl int_ctrl_i (
		.clk100mhz (clk100mhz),
		.rst_i     (sys_rst_o),
		.bus_s     (wb_intc),
		.src_i     (int_src),
		.irq_o     (irq_o)
	);

endmodule

//--- bench/clk_gen.sv
`timescale 1ns/1ns
// Testbench clock and power-on reset: 100 MHz clock, reset held for the first 4 edges.
module clk_gen #(
	parameter int HALF_PERIOD = 5,
	parameter int RESET_EDGES = 4
) (
	output logic clk100mhz_o,
	output logic por_o
);

	initial begin
		clk100mhz_o = 1'b0;
		forever #HALF_PERIOD clk100mhz_o = ~clk100mhz_o;
	end

	// reset leaves on a falling edge, like every other input.
	initial begin
		por_o = 1'b1;
		repeat (RESET_EDGES) @(posedge clk100mhz_o);
		@(negedge clk100mhz_o);
		por_o = 1'b0;
	end

endmodule

//--- bench/soc_tb.sv
`timescale 1ns/1ns
// System testbench: drives the external Wishbone master port through reset,
// device table, GPIO, interrupt and software reset tests.
module soc_tb;

	localparam int GPIO_W       = 16;
	localparam int RESET_CYCLES = 20;
	localparam int ACT_HOLD     = 15;
	localparam int CLK_PERIOD   = 10;
	localparam int ACK_LIMIT    = 8; // cycles a slave may take to ack.
	localparam int IRQ_LIMIT    = 10;
	localparam int ACC          = ACK_LIMIT + 2; // one access with its idle cycle.

	// cycle allowance of each test, in test order.
	localparam int BUDGET = (RESET_CYCLES + 8) + 4 * ACC + (2 * ACT_HOLD + 8 * ACC) +
		(7 * ACC + 2 * IRQ_LIMIT + 8) + (2 * RESET_CYCLES + 4 * ACC + 12);

	logic                  clk100mhz;
	logic                  por;
	logic                  rst_pulse;
	logic                  rst_p;
	logic                  wb_cyc_i;
	logic                  wb_stb_i;
	logic                  wb_we_i;
	soc_bus_pkg::wb_addr_t wb_adr_i;
	soc_bus_pkg::wb_data_t wb_dat_i;
	soc_bus_pkg::wb_sel_t  wb_sel_i;
	soc_bus_pkg::wb_data_t wb_dat_o;
	logic                  wb_ack_o;
	logic [GPIO_W-1:0]     gp_i;
	logic [GPIO_W-1:0]     gp_o;
	logic                  irq_o;
	logic                  activity_o;
	logic                  sys_rst_o;
	logic                  pwr_off_o;

	int          errors = 0;
	int          err_mark = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          cycle = 0;
	int          act_cycles[$]; // cycle numbers of every activity pulse.
	logic [31:0] rng;

	assign rst_p = por | rst_pulse;

	clk_gen clk_gen_i (
		.clk100mhz_o (clk100mhz),
		.por_o       (por)
	);

	soc_top #(
		.GPIO_W       (GPIO_W),
		.RESET_CYCLES (RESET_CYCLES),
		.ACT_HOLD     (ACT_HOLD)
	) soc_top_i (.*);

	always @(posedge clk100mhz) cycle <= cycle + 1;

	always @(negedge clk100mhz) begin
		if (activity_o === 1'b1)
			act_cycles.push_back(cycle);
	end

	// ******************************
	// checks and helpers
	// ******************************
	task automatic compare_data(input string name, input soc_bus_pkg::wb_data_t exp,
		input soc_bus_pkg::wb_data_t act);
		if (act !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic compare_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic compare_gpio(input string name, input logic [GPIO_W-1:0] exp,
		input logic [GPIO_W-1:0] act);
		if (act !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] s;
		s = state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// one classic cycle, driven on the falling edge and held until ack.
	task automatic bus_cycle(input logic we, input soc_bus_pkg::wb_addr_t adr,
		input soc_bus_pkg::wb_data_t wdata, output soc_bus_pkg::wb_data_t rdata);
		int waited;
		waited = 0;
		rdata  = '0;
		@(negedge clk100mhz);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = we;
		wb_adr_i = adr;
		wb_dat_i = wdata;
		wb_sel_i = '1;
		do begin
			@(negedge clk100mhz);
			waited++;
		end while (wb_ack_o !== 1'b1 && waited < ACK_LIMIT);
		if (wb_ack_o === 1'b1)
			rdata = wb_dat_o;
		else begin
			errors++;
			$display("%0t ns: no acknowledge from address %h", $time, adr);
		end
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
	endtask

	task automatic wb_write(input soc_bus_pkg::wb_addr_t adr, input soc_bus_pkg::wb_data_t data);
		soc_bus_pkg::wb_data_t unused;
		bus_cycle(1'b1, adr, data, unused);
	endtask

	task automatic wb_read(input soc_bus_pkg::wb_addr_t adr, output soc_bus_pkg::wb_data_t data);
		bus_cycle(1'b0, adr, '0, data);
	endtask

	task automatic read_expect(input soc_bus_pkg::wb_addr_t adr,
		input soc_bus_pkg::wb_data_t exp, input string name);
		soc_bus_pkg::wb_data_t got;
		wb_read(adr, got);
		compare_data(name, exp, got);
	endtask

	task automatic check_reset_release(input string name);
		for (int i = 1; i <= RESET_CYCLES; i++) begin
			@(negedge clk100mhz);
			compare_bit(name, (i < RESET_CYCLES), sys_rst_o); // low only after the last edge.
		end
	endtask

	task automatic wait_irq(input logic level);
		int waited;
		waited = 0;
		while (irq_o !== level && waited < IRQ_LIMIT) begin
			@(negedge clk100mhz);
			waited++;
		end
		if (irq_o !== level) begin
			errors++;
			$display("%0t ns: irq_o did not reach %b within %0d cycles", $time, level, IRQ_LIMIT);
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == err_mark)
			$display("test %0d, %s: ok", tests_run, name);
		else begin
			tests_failed++;
			$display("test %0d, %s: %0d errors", tests_run, name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	// ******************************
	// tests
	// ******************************
	task automatic power_on_reset();
		wait (rst_p === 1'b1);
		wait (rst_p === 1'b0);
		check_reset_release("sys_rst_o after power-on");
		compare_gpio("gp_o", '0, gp_o);
		compare_bit("irq_o", 1'b0, irq_o);
		compare_bit("pwr_off_o", 1'b0, pwr_off_o);
		compare_bit("activity_o", 1'b0, activity_o);
	endtask

	task automatic device_table_test();
		for (int k = 0; k < 3; k++)
			read_expect(16'(4 * k), {16'(k + 1), 8'h00, 8'd12}, "device descriptor");
		read_expect(16'h000c, '0, "device table word 3");
	endtask

	task automatic gpio_activity_test();
		logic [GPIO_W-1:0] pattern;
		int                mark;
		int                first;
		repeat (ACT_HOLD + 4) @(negedge clk100mhz); // let the hold counter run out.
		mark    = act_cycles.size();
		rng     = xorshift(rng);
		pattern = rng[GPIO_W-1:0];
		wb_write(16'h1004, 32'(pattern));
		compare_gpio("gp_o", pattern, gp_o);
		read_expect(16'h1004, 32'(pattern), "gpio output register");
		compare_bit("activity_o pulse", 1'b1, act_cycles.size() > mark);
		first = (act_cycles.size() > mark) ? act_cycles[mark] : cycle;
		while (cycle < first + ACT_HOLD + 2)
			read_expect(16'h1004, 32'(pattern), "gpio output register");
		@(negedge clk100mhz);
		compare_bit("activity_o early repeat", 1'b0,
			(act_cycles.size() > mark + 1) && (act_cycles[mark + 1] - first <= ACT_HOLD));
		rng  = xorshift(rng);
		gp_i = rng[GPIO_W-1:0];
		repeat (2) @(negedge clk100mhz); // two synchronizer stages.
		read_expect(16'h1000, 32'(gp_i), "gpio input");
	endtask

	task automatic interrupt_test();
		wb_write(16'h2000, 32'h3); // drop what the input change left pending.
		wb_write(16'h2004, 32'h1);
		read_expect(16'h2004, 32'h1, "intc enable");
		compare_bit("irq_o before change", 1'b0, irq_o);
		gp_i = ~gp_i;
		wait_irq(1'b1);
		read_expect(16'h2000, 32'h1, "intc pending after gpio change");
		wb_write(16'h2000, 32'h1);
		wait_irq(1'b0);
		read_expect(16'h5000, '0, "unmapped region data");
		read_expect(16'h2000, 32'h2, "intc pending after bus error");
		repeat (4) begin
			@(negedge clk100mhz);
			compare_bit("irq_o with bus error disabled", 1'b0, irq_o);
		end
	endtask

	task automatic software_reset_test();
		logic [GPIO_W-1:0] pattern;
		rng     = xorshift(rng);
		pattern = rng[GPIO_W-1:0] | 1'b1; // never zero, so the clear is visible.
		wb_write(16'h1004, 32'(pattern));
		compare_gpio("gp_o before warm reset", pattern, gp_o);
		wb_write(16'h0010, 32'(soc_map_pkg::RST_CMD_WARM));
		@(negedge clk100mhz);
		compare_bit("sys_rst_o after warm command", 1'b1, sys_rst_o);
		check_reset_release("sys_rst_o after warm command");
		compare_gpio("gp_o after warm reset", '0, gp_o);
		wb_write(16'h0010, 32'(soc_map_pkg::RST_CMD_OFF));
		repeat (8) begin
			@(negedge clk100mhz);
			compare_bit("pwr_off_o", 1'b1, pwr_off_o);
			compare_bit("sys_rst_o while off", 1'b1, sys_rst_o);
		end
		rst_pulse = 1'b1;
		@(negedge clk100mhz);
		rst_pulse = 1'b0;
		compare_bit("pwr_off_o after rst_p", 1'b0, pwr_off_o);
		check_reset_release("sys_rst_o after rst_p");
	endtask

	// ******************************
	// sequence and watchdog
	// ******************************
	initial begin
		wb_cyc_i  = 1'b0;
		wb_stb_i  = 1'b0;
		wb_we_i   = 1'b0;
		wb_adr_i  = '0;
		wb_dat_i  = '0;
		wb_sel_i  = '0;
		gp_i      = '0;
		rst_pulse = 1'b0;
		rng       = 32'h9104_79cf;
		power_on_reset();
		finish_test("power-on reset");
		device_table_test();
		finish_test("device table");
		gpio_activity_test();
		finish_test("gpio and activity");
		interrupt_test();
		finish_test("interrupts");
		software_reset_test();
		finish_test("software reset");
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		#(2 * BUDGET * CLK_PERIOD);
		$display("watchdog: the run went past its budget of %0d cycles", 2 * BUDGET);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- tb.f
rtl/soc_bus_pkg.sv
rtl/soc_map_pkg.sv
rtl/wb_if.sv
rtl/sys_ctrl.sv
rtl/bus_decoder.sv
rtl/dev_table.sv
rtl/gpio_port.sv
rtl/int_ctrl.sv
rtl/soc_top.sv
bench/clk_gen.sv
bench/soc_tb.sv

//--- Makefile
TOP := soc_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
